//--- verilog.f
design/biu_pkg.sv
design/cache_pkg.sv
design/cache_pipe_if.sv
design/cache_tag_stage.sv
design/cache_ram.sv
design/cache_hit_stage.sv
design/cache_top.sv
testbench/cache_tb_asserts.sv
testbench/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -f verilog.f -o cache_sim

out=$(./obj_dir/cache_sim)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
  exit 0
else
  exit 1
fi

//--- testbench/cache_tb.sv
//////////////////////////////////////////////////
// Data cache testbench
// LFSR stimulus, memory model with shadow state,
// reference read and response checker
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_tb
  import biu_pkg::*;
  import cache_pkg::*;
();

  localparam int TIMEOUT = 200;

  typedef struct packed {
    biu_adr_t  adr;
    biu_size_t size;
    logic      we;
    biu_data_t d;
    logic      fast;
    int        cyc;
  } req_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic cpu_req_i, cpu_flush_i, cpu_we_i, cpu_cacheable_i;
  biu_adr_t  cpu_adr_i;
  biu_size_t cpu_size_i;
  biu_data_t cpu_d_i;
  logic cpu_ready_o, cpu_ack_o, cpu_err_o;
  biu_data_t cpu_q_o;
  logic mem_req_o, mem_we_o, mem_ack_i;
  biu_adr_t mem_adr_o;
  biu_be_t mem_be_o;
  biu_data_t mem_d_o, mem_q_i;

  // 1 KiB memory that also holds the shadow of what the CPU should read
  biu_data_t mem [256];
  req_t pend[$];
  int errors, fails, tests, t_err, cyc, acks, bus_rd, bus_wr;
  string test_name;
  logic [31:0] stim_lfsr;
  logic [31:0] dly_lfsr;

  cache_top dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  ///////////////////////////////////////////////////
  // Helpers and reference model
  ///////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] draw(input int n, inout logic [31:0] st);
    logic        fb;
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = st[31] ^ st[21] ^ st[1] ^ st[0];
      st = {st[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Wrong value with its expected and actual value
  task automatic wrong_value(string what, logic [31:0] exp_v, logic [31:0] act_v);
    $display("ERR %s %s exp %0h act %0h", test_name, what, exp_v, act_v);
    errors++;
  endtask

  // Any other failure, described in words
  task automatic count_failure(string msg);
    $display("%s in %s", msg, test_name);
    errors++;
  endtask

  function automatic biu_be_t calc_be(biu_adr_t a, biu_size_t s);
    case (s)
      BYTE:    return biu_be_t'(4'b0001) << a[1:0];
      HWORD:   return biu_be_t'(4'b0011) << a[1:0];
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic is_mis(biu_adr_t a, biu_size_t s);
    return (s == HWORD && a[0]) || (s == WORD && a[1:0] != 2'b00);
  endfunction

  function automatic biu_data_t lane_mask(biu_be_t be);
    biu_data_t m;
    for (int b = 0; b < 4; b++)
      m[8*b +: 8] = {8{be[b]}};
    return m;
  endfunction

  // Shadow word with the unaddressed lanes zero
  function automatic biu_data_t ref_read(biu_adr_t a, biu_size_t s);
    return mem[a[9:2]] & lane_mask(calc_be(a, s));
  endfunction

  ///////////////////////////////////////////////////
  // Memory model
  ///////////////////////////////////////////////////

  task automatic check_bus();
    req_t      f;
    biu_data_t m;
    assert (pend.size() != 0)
      else count_failure("Bus request with no pending CPU request");
    if (pend.size() != 0)
    begin
      f = pend[0];
      m = lane_mask(calc_be(f.adr, f.size));
      assert (!is_mis(f.adr, f.size))
        else count_failure("Bus access for a misaligned request");
      assert (mem_we_o == f.we)
        else wrong_value("we", f.we, mem_we_o);
      if (f.we)
      begin
        assert (mem_adr_o == f.adr)
          else wrong_value("adr", f.adr, mem_adr_o);
        assert (mem_be_o == calc_be(f.adr, f.size))
          else wrong_value("be", calc_be(f.adr, f.size), mem_be_o);
        assert ((mem_d_o & m) == (f.d & m))
          else wrong_value("wdata", f.d & m, mem_d_o & m);
      end
      else
      begin
        // Refill reads stay within the requested line
        assert (mem_adr_o[31:4] == f.adr[31:4])
          else wrong_value("rd adr", f.adr, mem_adr_o);
      end
    end
  endtask

  initial
  begin
    logic [31:0] v;
    int wait_n;
    wait_n = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (mem_ack_i)
      begin
        // Transfer completed at this edge
        mem_ack_i = 1'b0;
        v = draw(2, dly_lfsr);
        wait_n = int'(v);
      end
      else if (mem_req_o)
      begin
        if (wait_n > 0)
          wait_n--;
        else
        begin
          check_bus();
          if (mem_we_o)
          begin
            for (int b = 0; b < 4; b++)
              if (mem_be_o[b])
                mem[mem_adr_o[9:2]][8*b +: 8] = mem_d_o[8*b +: 8];
            bus_wr++;
          end
          else
          begin
            mem_q_i = mem[mem_adr_o[9:2]];
            bus_rd++;
          end
          mem_ack_i = 1'b1;
        end
      end
    end
  end

  ///////////////////////////////////////////////////
  // Response checker
  ///////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    req_t e;
    biu_data_t exp;
    if (rst_ni && cpu_ack_o)
    begin
      acks++;
      assert (pend.size() != 0)
        else count_failure("Ack without a pending request");
      if (pend.size() != 0)
      begin
        e = pend.pop_front();
        if (is_mis(e.adr, e.size))
        begin
          assert (cpu_err_o)
            else wrong_value("err", 1, cpu_err_o);
        end
        else
        begin
          assert (!cpu_err_o)
            else wrong_value("err", 0, cpu_err_o);
          exp = ref_read(e.adr, e.size);
          if (!e.we)
          begin
            assert (cpu_q_o == exp)
              else wrong_value("rdata", exp, cpu_q_o);
          end
        end
        // Hits answer in the cycle after acceptance
        if (e.fast)
        begin
          assert (cyc == e.cyc)
            else wrong_value("ack cycle", e.cyc, cyc);
        end
      end
    end
  end

  ///////////////////////////////////////////////////
  // CPU driver
  ///////////////////////////////////////////////////

  task automatic issue(biu_adr_t a, biu_size_t s, logic we, biu_data_t d, logic cach,
                       logic fast, logic fl);
    int t;
    cpu_req_i = 1'b1;
    cpu_flush_i = fl;
    cpu_adr_i = a;
    cpu_size_i = s;
    cpu_we_i = we;
    cpu_d_i = d;
    cpu_cacheable_i = cach;
    t = 0;
    @(negedge clk_i);
    while (!cpu_ready_o && t < TIMEOUT)
    begin
      @(negedge clk_i);
      t++;
    end
    if (!cpu_ready_o)
      count_failure("Timeout waiting for cpu_ready_o");
    @(posedge clk_i);
    #1;
    if (t < TIMEOUT && !fl)
      pend.push_back('{adr: a, size: s, we: we, d: d, fast: fast, cyc: cyc});
  endtask

  task automatic drain();
    int t;
    cpu_req_i = 1'b0;
    cpu_flush_i = 1'b0;
    t = 0;
    while (pend.size() != 0 && t < TIMEOUT)
    begin
      @(negedge clk_i);
      t++;
    end
    if (pend.size() != 0)
    begin
      count_failure("Timeout waiting for cpu_ack_o");
      pend.delete();
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic start_test(string name);
    test_name = name;
    t_err = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == t_err)
      $display("PASS %s", test_name);
    else
    begin
      fails++;
      $display("FAIL %s with %0d errors", test_name, errors - t_err);
    end
  endtask

  ///////////////////////////////////////////////////
  // Test sequence
  ///////////////////////////////////////////////////

  initial
  begin
    logic [31:0] v, w;
    int r0, w0, a0;
    biu_size_t s;
    for (int i = 0; i < 256; i++)
      mem[i] = (32'h9e37_79b9 * (i + 1)) ^ {24'h0, 8'(i)};
    stim_lfsr = 32'h7752_acc8;
    dly_lfsr = 32'h7752_acc8;
    {cpu_req_i, cpu_flush_i, cpu_we_i, cpu_cacheable_i} = '0;
    cpu_adr_i = '0;
    cpu_size_i = WORD;
    cpu_d_i = '0;
    mem_ack_i = 1'b0;
    mem_q_i = '0;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    start_test("read_miss_hits");
    r0 = bus_rd;
    issue(32'h40, WORD, 0, 0, 1, 0, 0);
    drain();
    assert (bus_rd - r0 == 4)
      else wrong_value("refill reads", 4, bus_rd - r0);
    issue(32'h44, WORD, 0, 0, 1, 1, 0);
    issue(32'h4a, HWORD, 0, 0, 1, 1, 0);
    issue(32'h4d, BYTE, 0, 0, 1, 1, 0);
    drain();
    end_test();

    start_test("write_through");
    w0 = bus_wr;
    v = draw(32, stim_lfsr);
    issue(32'h41, BYTE, 1, v, 1, 0, 0);
    issue(32'h46, HWORD, 1, ~v, 1, 0, 0);
    issue(32'h48, WORD, 1, v ^ 32'h0f0f_0f0f, 1, 0, 0);
    issue(32'h1a3, BYTE, 1, v, 1, 0, 0);
    issue(32'h40, WORD, 0, 0, 1, 0, 0);
    issue(32'h44, WORD, 0, 0, 1, 0, 0);
    issue(32'h48, WORD, 0, 0, 1, 0, 0);
    issue(32'h1a0, WORD, 0, 0, 1, 0, 0);
    drain();
    assert (bus_wr - w0 == 4)
      else wrong_value("bus writes", 4, bus_wr - w0);
    end_test();

    start_test("misaligned");
    r0 = bus_rd;
    w0 = bus_wr;
    issue(32'h81, HWORD, 0, 0, 1, 1, 0);
    issue(32'h86, WORD, 0, 0, 1, 1, 0);
    issue(32'h8a, WORD, 1, 32'h1234_5678, 1, 1, 0);
    drain();
    assert (bus_rd == r0 && bus_wr == w0)
      else count_failure("Bus traffic for misaligned accesses");
    end_test();

    start_test("uncached");
    r0 = bus_rd;
    issue(32'h2c0, WORD, 0, 0, 0, 0, 0);
    issue(32'h2c0, WORD, 0, 0, 0, 0, 0);
    drain();
    assert (bus_rd - r0 == 2)
      else wrong_value("bus reads", 2, bus_rd - r0);
    end_test();

    start_test("conflict_random");
    issue(32'h100, WORD, 0, 0, 1, 0, 0);
    issue(32'h200, WORD, 0, 0, 1, 0, 0);
    issue(32'h104, WORD, 0, 0, 1, 0, 0);
    for (int n = 0; n < 300; n++)
    begin
      w = draw(2, stim_lfsr);
      case (w[1:0])
        2'd0:    s = BYTE;
        2'd1:    s = HWORD;
        default: s = WORD;
      endcase
      v = draw(10, stim_lfsr);
      w = draw(2, stim_lfsr);
      a0 = int'(w[1:0]);
      w = draw(32, stim_lfsr);
      issue({22'h0, v[9:0]}, s, a0 == 0, w, a0 != 1, 0, 0);
    end
    drain();
    end_test();

    start_test("flush");
    issue(32'h40, WORD, 0, 0, 1, 0, 0);
    drain();
    a0 = acks;
    issue(32'h48, WORD, 0, 0, 1, 0, 1);
    cpu_req_i = 1'b0;
    cpu_flush_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    assert (acks == a0)
      else count_failure("Flushed request was acknowledged");
    issue(32'h44, WORD, 0, 0, 1, 0, 0);
    drain();
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests, fails, errors);
    if (fails == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // Overall limit on the run
  initial
  begin
    #1000000;
    $display("Simulation did not finish in time");
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- testbench/cache_tb_asserts.sv
//////////////////////////////////////////////////
// Data cache handshake assertions
// Bound to the cache top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_tb_asserts
  import biu_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      cpu_ack_o,
  input logic      cpu_ready_o,
  input logic      mem_req_o,
  input logic      mem_we_o,
  input biu_adr_t  mem_adr_o,
  input biu_be_t   mem_be_o,
  input biu_data_t mem_d_o,
  input logic      mem_ack_i
);

  // Bus request and its fields hold until ack
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_we_o) &&
    $stable(mem_adr_o) && $stable(mem_be_o) && $stable(mem_d_o))
    else $error("Memory request changed before its ack");

  // No response while reset is applied
  assert property (@(posedge clk_i) !rst_ni |-> !cpu_ack_o)
    else $error("CPU ack during reset");

  // CPU side is stalled during any bus transfer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> !cpu_ready_o)
    else $error("CPU ready high during a memory request");

endmodule

bind cache_top cache_tb_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cpu_ack_o   (cpu_ack_o),
  .cpu_ready_o (cpu_ready_o),
  .mem_req_o   (mem_req_o),
  .mem_we_o    (mem_we_o),
  .mem_adr_o   (mem_adr_o),
  .mem_be_o    (mem_be_o),
  .mem_d_o     (mem_d_o),
  .mem_ack_i   (mem_ack_i)
);

//--- design/cache_top.sv
//////////////////////////////////////////////////
// Data cache top level
// Direct mapped write-through cache between the
// load/store unit and the memory bus
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_top
  import biu_pkg::*;
  import cache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // CPU side
  input  logic      cpu_req_i,
  output logic      cpu_ready_o,
  input  logic      cpu_flush_i,
  input  biu_adr_t  cpu_adr_i,
  input  biu_size_t cpu_size_i,
  input  logic      cpu_we_i,
  input  biu_data_t cpu_d_i,
  input  logic      cpu_cacheable_i,
  output logic      cpu_ack_o,
  output biu_data_t cpu_q_o,
  output logic      cpu_err_o,
  // Memory side
  output logic      mem_req_o,
  output logic      mem_we_o,
  output biu_adr_t  mem_adr_o,
  output biu_be_t   mem_be_o,
  output biu_data_t mem_d_o,
  input  logic      mem_ack_i,
  input  biu_data_t mem_q_i
);

  logic        stall;
  logic        flush;
  cache_idx_t  rd_idx;
  cache_tag_t  rd_tag;
  logic        rd_valid;
  cache_line_t rd_line;
  logic        wr;
  cache_idx_t  wr_idx;
  cache_ofs_t  wr_ofs;
  biu_be_t     wr_be;
  biu_data_t   wr_d;
  logic        set_valid;
  cache_tag_t  set_tag;

  cache_pipe_if pipe ();

  assign cpu_ready_o = ~stall;

  // Kill only while the hit stage is not working on the request
  assign flush = cpu_flush_i & ~stall;

  // Array index follows whatever enters the hit stage next
  assign rd_idx = stall ? pipe.adr[BYTE_BITS+OFS_BITS +: IDX_BITS]
                        : cpu_adr_i[BYTE_BITS+OFS_BITS +: IDX_BITS];

  cache_tag_stage u_tag_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall),
    .flush_i     (flush),
    .req_i       (cpu_req_i),
    .adr_i       (cpu_adr_i),
    .size_i      (cpu_size_i),
    .we_i        (cpu_we_i),
    .d_i         (cpu_d_i),
    .cacheable_i (cpu_cacheable_i),
    .pipe        (pipe.stage_mp)
  );

  cache_ram u_ram (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_idx_i    (rd_idx),
    .rd_tag_o    (rd_tag),
    .rd_valid_o  (rd_valid),
    .rd_line_o   (rd_line),
    .wr_i        (wr),
    .wr_idx_i    (wr_idx),
    .wr_ofs_i    (wr_ofs),
    .wr_be_i     (wr_be),
    .wr_d_i      (wr_d),
    .set_valid_i (set_valid),
    .set_tag_i   (set_tag)
  );

  cache_hit_stage u_hit_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pipe        (pipe.hit_mp),
    .rd_tag_i    (rd_tag),
    .rd_valid_i  (rd_valid),
    .rd_line_i   (rd_line),
    .wr_o        (wr),
    .wr_idx_o    (wr_idx),
    .wr_ofs_o    (wr_ofs),
    .wr_be_o     (wr_be),
    .wr_d_o      (wr_d),
    .set_valid_o (set_valid),
    .set_tag_o   (set_tag),
    .stall_o     (stall),
    .cpu_ack_o   (cpu_ack_o),
    .cpu_q_o     (cpu_q_o),
    .cpu_err_o   (cpu_err_o),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_adr_o   (mem_adr_o),
    .mem_be_o    (mem_be_o),
    .mem_d_o     (mem_d_o),
    .mem_ack_i   (mem_ack_i),
    .mem_q_i     (mem_q_i)
  );

endmodule

//--- design/cache_hit_stage.sv
//////////////////////////////////////////////////
// Data cache hit stage
// Tag compare and CPU response, line refill on a
// read miss, write-through and uncached reads
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_hit_stage
  import biu_pkg::*;
  import cache_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  cache_pipe_if.hit_mp  pipe,
  // Array read result for the request in this stage
  input  cache_tag_t    rd_tag_i,
  input  logic          rd_valid_i,
  input  cache_line_t   rd_line_i,
  // Array write side
  output logic          wr_o,
  output cache_idx_t    wr_idx_o,
  output cache_ofs_t    wr_ofs_o,
  output biu_be_t       wr_be_o,
  output biu_data_t     wr_d_o,
  output logic          set_valid_o,
  output cache_tag_t    set_tag_o,
  // Back-pressure to the tag stage and CPU
  output logic          stall_o,
  // CPU response
  output logic          cpu_ack_o,
  output biu_data_t     cpu_q_o,
  output logic          cpu_err_o,
  // Memory bus
  output logic          mem_req_o,
  output logic          mem_we_o,
  output biu_adr_t      mem_adr_o,
  output biu_be_t       mem_be_o,
  output biu_data_t     mem_d_o,
  input  logic          mem_ack_i,
  input  biu_data_t     mem_q_i
);

  // Expand byte enables to a bit mask
  function automatic biu_data_t be2mask(input biu_be_t be);
    biu_data_t mask;
    for (int b = 0; b < XLEN/8; b++)
    begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  hit_state_t state_q;
  hit_state_t state_d;
  cache_ofs_t cnt_q;
  logic       done_q;
  logic       reread_q;
  biu_data_t  q_q;
  cache_tag_t req_tag;
  cache_idx_t req_idx;
  cache_ofs_t req_ofs;
  logic       tag_hit;
  logic       refill_last;
  biu_data_t  q_mask;

  ///////////////////////////////////////////////////
  // Tag compare and word select
  ///////////////////////////////////////////////////

  assign req_tag = pipe.adr[PLEN-1 -: TAG_BITS];
  assign req_idx = pipe.adr[BYTE_BITS+OFS_BITS +: IDX_BITS];
  assign req_ofs = pipe.adr[BYTE_BITS +: OFS_BITS];

  assign tag_hit = rd_valid_i && (rd_tag_i == req_tag);

  // Sub-word reads return only the addressed lanes
  always_comb
  begin
    case (pipe.size)
      WORD:    q_mask = '1;
      default: q_mask = be2mask(pipe.be);
    endcase
  end

  // Bus data after an uncached read, else the cached word
  assign cpu_q_o = (done_q ? q_q : rd_line_i[req_ofs]) & q_mask;

  ///////////////////////////////////////////////////
  // FSM
  ///////////////////////////////////////////////////

  assign refill_last = (state_q == REFILL_S) && mem_ack_i &&
                       (cnt_q == cache_ofs_t'(LINE_WORDS-1));

  always_comb
  begin
    state_d   = state_q;
    stall_o   = 1'b0;
    cpu_ack_o = 1'b0;
    cpu_err_o = 1'b0;
    unique case (state_q)
      IDLE_S:
      begin
        if (reread_q)
          // Refilled line is being read back
          stall_o = 1'b1;
        else if (done_q)
          // Bus transfer finished, request still in the pipe
          cpu_ack_o = 1'b1;
        else if (pipe.req)
        begin
          if (pipe.misaligned)
          begin
            cpu_ack_o = 1'b1;
            cpu_err_o = 1'b1;
          end
          else if (pipe.we)
          begin
            stall_o = 1'b1;
            state_d = BUSWR_S;
          end
          else if (!pipe.cacheable)
          begin
            stall_o = 1'b1;
            state_d = BUSRD_S;
          end
          else if (tag_hit)
            cpu_ack_o = 1'b1;
          else
          begin
            stall_o = 1'b1;
            state_d = REFILL_S;
          end
        end
      end
      REFILL_S:
      begin
        stall_o = 1'b1;
        if (refill_last)
          state_d = IDLE_S;
      end
      BUSWR_S, BUSRD_S:
      begin
        stall_o = 1'b1;
        if (mem_ack_i)
          state_d = IDLE_S;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q  <= IDLE_S;
      cnt_q    <= '0;
      done_q   <= 1'b0;
      reread_q <= 1'b0;
    end
    else
    begin
      state_q  <= state_d;
      done_q   <= ((state_q == BUSWR_S) || (state_q == BUSRD_S)) && mem_ack_i;
      reread_q <= refill_last;
      // Wraps back to word 0 after the last word
      if ((state_q == REFILL_S) && mem_ack_i)
        cnt_q <= cnt_q + 1'b1;
    end
  end

  // Uncached read data held for the ack cycle
  always_ff @(posedge clk_i)
  begin
    if ((state_q == BUSRD_S) && mem_ack_i)
      q_q <= mem_q_i;
  end

  ///////////////////////////////////////////////////
  // Memory bus and array update
  ///////////////////////////////////////////////////

  // Fields only change on ack, so they hold while req is up
  assign mem_req_o = (state_q != IDLE_S);
  assign mem_we_o  = (state_q == BUSWR_S);
  assign mem_adr_o = (state_q == REFILL_S) ?
                     {req_tag, req_idx, cnt_q, {BYTE_BITS{1'b0}}} : pipe.adr;
  assign mem_be_o  = (state_q == REFILL_S) ? '1 : pipe.be;
  assign mem_d_o   = pipe.d;

  // Refill words, or a store that hits the line
  assign wr_o     = mem_ack_i &&
                    ((state_q == REFILL_S) || ((state_q == BUSWR_S) && tag_hit));
  assign wr_idx_o = req_idx;
  assign wr_ofs_o = (state_q == REFILL_S) ? cnt_q : req_ofs;
  assign wr_be_o  = (state_q == REFILL_S) ? '1 : pipe.be;
  assign wr_d_o   = (state_q == REFILL_S) ? mem_q_i : pipe.d;

  // Line becomes valid with its last word
  assign set_valid_o = refill_last;
  assign set_tag_o   = req_tag;

endmodule

//--- design/cache_ram.sv
//////////////////////////////////////////////////
// Data cache storage
// Valid bits, tag array and data array with one
// synchronous read port and one write port
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_ram
  import biu_pkg::*;
  import cache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Read port, result one cycle later
  input  cache_idx_t  rd_idx_i,
  output cache_tag_t  rd_tag_o,
  output logic        rd_valid_o,
  output cache_line_t rd_line_o,
  // Word write port
  input  logic        wr_i,
  input  cache_idx_t  wr_idx_i,
  input  cache_ofs_t  wr_ofs_i,
  input  biu_be_t     wr_be_i,
  input  biu_data_t   wr_d_i,
  // Line allocation
  input  logic        set_valid_i,
  input  cache_tag_t  set_tag_i
);

  logic [SETS-1:0] valid_q;
  cache_tag_t      tag_mem  [SETS];
  cache_line_t     data_mem [SETS];

  // Valid bits, all lines empty after reset
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= '0;
    else if (set_valid_i)
      valid_q[wr_idx_i] <= 1'b1;
  end

  // Tag is written together with the valid bit
  always_ff @(posedge clk_i)
  begin
    if (set_valid_i)
      tag_mem[wr_idx_i] <= set_tag_i;
  end

  // Byte-masked word write
  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < XLEN/8; b++)
    begin
      if (wr_i && wr_be_i[b])
        data_mem[wr_idx_i][wr_ofs_i][8*b +: 8] <= wr_d_i[8*b +: 8];
    end
  end

  // Synchronous read, returns old contents on a same-cycle write
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rd_valid_o <= 1'b0;
    else
      rd_valid_o <= valid_q[rd_idx_i];
  end

  always_ff @(posedge clk_i)
  begin
    rd_tag_o  <= tag_mem[rd_idx_i];
    rd_line_o <= data_mem[rd_idx_i];
  end

endmodule

//--- design/cache_tag_stage.sv
//////////////////////////////////////////////////
// Data cache tag stage
// Registers the CPU request while the array is
// read, builds byte enables, checks alignment
//////////////////////////////////////////////////

`timescale 1ns/1ns

module cache_tag_stage
  import biu_pkg::*;
  import cache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_i,
  input  logic                  flush_i,
  input  logic                  req_i,
  input  biu_adr_t              adr_i,
  input  biu_size_t             size_i,
  input  logic                  we_i,
  input  biu_data_t             d_i,
  input  logic                  cacheable_i,
  cache_pipe_if.stage_mp        pipe
);

  biu_be_t size_mask;
  biu_be_t be;
  logic    misaligned;

  // Lanes covered by the access before shifting
  always_comb
  begin
    case (size_i)
      BYTE:    size_mask = biu_be_t'(4'b0001);
      HWORD:   size_mask = biu_be_t'(4'b0011);
      WORD:    size_mask = biu_be_t'(4'b1111);
      default: size_mask = '0;
    endcase
  end

  // Move the mask to the addressed lanes
  assign be = size_mask << adr_i[BYTE_BITS-1:0];

  // Half words need even, words need 4-byte aligned addresses
  always_comb
  begin
    case (size_i)
      HWORD:   misaligned = adr_i[0];
      WORD:    misaligned = |adr_i[BYTE_BITS-1:0];
      default: misaligned = 1'b0;
    endcase
  end

  // Request valid, killed by flush
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pipe.req <= 1'b0;
    else if (flush_i)
      pipe.req <= 1'b0;
    else if (!stall_i)
      pipe.req <= req_i;
  end

  // Payload, frozen during stall
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      pipe.adr        <= adr_i;
      pipe.size       <= size_i;
      pipe.we         <= we_i;
      pipe.be         <= be;
      pipe.d          <= d_i;
      pipe.cacheable  <= cacheable_i;
      pipe.misaligned <= misaligned;
    end
  end

endmodule

//--- design/cache_pipe_if.sv
//////////////////////////////////////////////////
// Tag stage to hit stage pipeline bundle
// Carries the registered CPU request
//////////////////////////////////////////////////

`timescale 1ns/1ns

interface cache_pipe_if
  import biu_pkg::*;
();

  // Request held in the tag stage
  logic      req;
  biu_adr_t  adr;
  biu_size_t size;
  logic      we;
  biu_be_t   be;
  biu_data_t d;
  logic      cacheable;
  logic      misaligned;

  // Tag stage drives the bundle
  modport stage_mp (output req, adr, size, we, be, d, cacheable, misaligned);

  // Hit stage consumes it
  modport hit_mp (input req, adr, size, we, be, d, cacheable, misaligned);

endinterface

//--- design/cache_pkg.sv
//////////////////////////////////////////////////
// Data cache definitions
// Geometry of the direct mapped cache and the
// types used to split an address and hold a line
//////////////////////////////////////////////////

package cache_pkg;

  ///////////////////////////////////////////////////
  // Geometry
  ///////////////////////////////////////////////////

  // Number of sets, one line each
  localparam int SETS       = 16;

  // 32-bit words per line
  localparam int LINE_WORDS = 4;

  // Address split: tag | index | word offset | byte
  localparam int IDX_BITS   = 4;
  localparam int OFS_BITS   = 2;
  localparam int BYTE_BITS  = 2;
  localparam int TAG_BITS   = biu_pkg::PLEN - IDX_BITS - OFS_BITS - BYTE_BITS;

  ///////////////////////////////////////////////////
  // Types
  ///////////////////////////////////////////////////

  typedef logic [TAG_BITS-1:0] cache_tag_t;
  typedef logic [IDX_BITS-1:0] cache_idx_t;
  typedef logic [OFS_BITS-1:0] cache_ofs_t;

  // Whole line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][biu_pkg::XLEN-1:0] cache_line_t;

  // Hit stage FSM
  typedef enum logic [1:0] {
    IDLE_S,    // compare tag, answer hits
    REFILL_S,  // four word reads of a missed line
    BUSWR_S,   // write-through of a store
    BUSRD_S    // single uncached read
  } hit_state_t;

endpackage

//--- design/biu_pkg.sv
//////////////////////////////////////////////////
// Bus interface definitions
// Data and address widths, transfer sizes and
// byte enables shared by the CPU and memory sides
//////////////////////////////////////////////////

package biu_pkg;

  // Data width, fixed for RV32
  localparam int XLEN = 32;

  // Physical address width
  localparam int PLEN = 32;

  // Access size as issued by the load/store unit
  // DWORD is not supported with XLEN = 32
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_t;

  // One bus data word
  typedef logic [XLEN-1:0] biu_data_t;

  // Physical byte address
  typedef logic [PLEN-1:0] biu_adr_t;

  // One enable per byte lane
  typedef logic [XLEN/8-1:0] biu_be_t;

endpackage
